// ==== hdl/isa_pkg.sv ====
package isa_pkg;

   // major opcode, insn[31:26]
   typedef logic [5:0] opcode_t;

   // l.nop, loaded into execute on bubble or flush
   localparam opcode_t OPCODE_NOP = 6'h05;

   // decoded operation flags, one bit per op class
   typedef logic [15:0] op_flags_t;

   localparam int OP_ALU     = 0;
   localparam int OP_ADD     = 1;
   localparam int OP_SHIFT   = 2;
   localparam int OP_MOVHI   = 3;
   localparam int OP_MFSPR   = 4;
   localparam int OP_MTSPR   = 5;
   localparam int OP_LOAD    = 6;
   localparam int OP_STORE   = 7;
   localparam int OP_ATOMIC  = 8;
   localparam int OP_SETFLAG = 9;
   localparam int OP_JBR     = 10;
   localparam int OP_JR      = 11;
   localparam int OP_JAL     = 12;
   localparam int OP_BRCOND  = 13;
   localparam int OP_BRANCH  = 14;
   // destination register is written back
   localparam int OP_RF_WB   = 15;

   typedef logic [3:0] alu_opc_t;

   // branch immediate is {immjbr_upper, imm16}, in words
   localparam int IMM16_WIDTH        = 16;
   localparam int IMMJBR_UPPER_WIDTH = 10;

endpackage

// ==== hdl/pipe_pkg.sv ====
package pipe_pkg;

   // rfe rides along with the exceptions so a flush clears it too
   typedef logic [3:0] exc_flags_t;

   localparam int EXC_RFE        = 0;
   localparam int EXC_ILLEGAL    = 1;
   localparam int EXC_SYSCALL    = 2;
   // taken branch to a target that is not word aligned
   localparam int EXC_IBUS_ALIGN = 3;

endpackage

// ==== hdl/stage_reg.sv ====
`timescale 1ns/1ps

module stage_reg #(
   parameter type payload_t = logic,
   parameter payload_t KILL_VALUE = '0,
   parameter bit KILL_ON_BUBBLE = 1'b0,
   parameter bit HAS_RESET = 1'b1
) (
   input  logic     clk,
   input  logic     rst,
   input  logic     padv_i,
   input  logic     flush_i,
   input  logic     bubble_i,
   input  payload_t d_i,
   output payload_t q_o
);

   // control registers are reset and also killed by a flush,
   // payload registers just follow the advance strobe
   always_ff @(posedge clk) begin
      if (HAS_RESET && (rst || flush_i)) begin
         q_o <= KILL_VALUE;
      end else if (padv_i) begin
         if (KILL_ON_BUBBLE && bubble_i) begin
            q_o <= KILL_VALUE;
         end else begin
            q_o <= d_i;
         end
      end
   end

   // a stalled stage keeps its contents
   hold_when_stalled: assert property (
      @(posedge clk) disable iff (rst)
      (!padv_i && !flush_i) |=> $stable(q_o)
   ) else $error("stage_reg changed while stalled");

endmodule

// ==== hdl/hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit #(
   parameter int RF_ADDR_WIDTH = 5
) (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     padv_i,
   input  logic                     flush_i,
   input  logic [RF_ADDR_WIDTH-1:0] decode_rfa_adr_i,
   input  logic [RF_ADDR_WIDTH-1:0] decode_rfb_adr_i,
   input  logic                     decode_op_jr_i,
   input  logic                     decode_op_rfe_i,
   input  isa_pkg::op_flags_t       execute_ops_i,
   input  logic [RF_ADDR_WIDTH-1:0] execute_rfd_adr_i,
   input  logic                     ctrl_op_load_i,
   input  logic                     ctrl_op_mfspr_i,
   input  logic [RF_ADDR_WIDTH-1:0] ctrl_rfd_adr_i,
   output logic                     decode_bubble_o,
   output logic                     ctrl_interlock_o,
   output logic                     jr_ready_o,
   output logic                     execute_bubble_o,
   output logic                     decode_valid_o
);

   logic exe_late_result;
   logic exe_src_match;
   logic exe_rfb_pending;
   logic load_use_hazard;
   logic jr_hazard;
   logic atomic_store;

   // load and mfspr results only appear in the control stage,
   // so nothing can be bypassed from there into decode
   assign ctrl_interlock_o = (ctrl_op_load_i | ctrl_op_mfspr_i) &
                             ((decode_rfa_adr_i == ctrl_rfd_adr_i) |
                              (decode_rfb_adr_i == ctrl_rfd_adr_i));

   assign exe_late_result = execute_ops_i[isa_pkg::OP_LOAD] |
                            execute_ops_i[isa_pkg::OP_MFSPR];
   assign exe_src_match   = (decode_rfa_adr_i == execute_rfd_adr_i) |
                            (decode_rfb_adr_i == execute_rfd_adr_i);
   assign load_use_hazard = exe_late_result & exe_src_match;

   // jr target register still being produced in execute
   assign exe_rfb_pending = execute_ops_i[isa_pkg::OP_RF_WB] &
                            (decode_rfb_adr_i == execute_rfd_adr_i);
   assign jr_ready_o      = decode_op_jr_i & !exe_rfb_pending;
   assign jr_hazard       = decode_op_jr_i & (ctrl_interlock_o | exe_rfb_pending);

   assign atomic_store = execute_ops_i[isa_pkg::OP_STORE] &
                         execute_ops_i[isa_pkg::OP_ATOMIC];

   // rfe bubbles to stall fetch while it travels to the control stage
   assign decode_bubble_o = (load_use_hazard | jr_hazard | atomic_store |
                             decode_op_rfe_i) & padv_i;

   always_ff @(posedge clk) begin
      if (rst || flush_i) begin
         execute_bubble_o <= 1'b0;
      end else if (padv_i) begin
         execute_bubble_o <= decode_bubble_o;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         decode_valid_o <= 1'b0;
      end else begin
         decode_valid_o <= padv_i;
      end
   end

   bubble_needs_advance: assert property (
      @(posedge clk) disable iff (rst)
      $rose(decode_bubble_o) |-> padv_i
   ) else $error("decode bubble raised without advance");

endmodule

// ==== hdl/branch_resolver.sv ====
`timescale 1ns/1ps

module branch_resolver #(
   parameter int OPERAND_WIDTH = 32,
   parameter bit DELAY_SLOT = 1'b1
) (
   input  logic                                       clk,
   input  logic                                       padv_i,
   input  logic                                       flush_i,
   input  logic [OPERAND_WIDTH-1:0]                   pc_decode_i,
   input  isa_pkg::op_flags_t                         decode_ops_i,
   input  isa_pkg::opcode_t                           decode_opc_insn_i,
   input  logic                                       decode_op_bf_i,
   input  logic                                       decode_op_bnf_i,
   input  logic [isa_pkg::IMM16_WIDTH-1:0]            decode_imm16_i,
   input  logic [isa_pkg::IMMJBR_UPPER_WIDTH-1:0]     decode_immjbr_upper_i,
   input  logic                                       predicted_flag_i,
   input  logic [OPERAND_WIDTH-1:0]                   decode_rfb_i,
   input  logic [OPERAND_WIDTH-1:0]                   execute_rfb_i,
   input  logic                                       ctrl_interlock_i,
   input  logic                                       jr_ready_i,
   input  logic                                       execute_bubble_i,
   input  isa_pkg::op_flags_t                         execute_ops_i,
   output logic                                       decode_branch_o,
   output logic [OPERAND_WIDTH-1:0]                   decode_branch_target_o,
   output logic                                       ibus_align_o,
   output logic                                       execute_predicted_flag_o,
   output logic [OPERAND_WIDTH-1:0]                   execute_mispredict_target_o,
   output logic [OPERAND_WIDTH-1:0]                   execute_jal_result_o
);

   // immediate bits plus the two word-offset zeros
   localparam int IMM_BITS = isa_pkg::IMMJBR_UPPER_WIDTH + isa_pkg::IMM16_WIDTH + 2;
   localparam int PC_STEP  = DELAY_SLOT ? 8 : 4;

   logic                     branch_to_imm;
   logic                     branch_to_reg;
   logic [OPERAND_WIDTH-1:0] imm_offset;
   logic [OPERAND_WIDTH-1:0] imm_target;
   logic [OPERAND_WIDTH-1:0] reg_target;
   logic [OPERAND_WIDTH-1:0] next_pc;
   logic [OPERAND_WIDTH-1:0] mispredict_target;

   // opcode bits [2:1] clear for l.j/l.jal, bit 2 tells l.bf from l.bnf
   assign branch_to_imm = decode_ops_i[isa_pkg::OP_JBR] &
                          (~|decode_opc_insn_i[2:1] |
                           (decode_opc_insn_i[2] == predicted_flag_i));

   assign imm_offset = {{(OPERAND_WIDTH-IMM_BITS){decode_immjbr_upper_i[
                         isa_pkg::IMMJBR_UPPER_WIDTH-1]}},
                        decode_immjbr_upper_i, decode_imm16_i, 2'b00};
   assign imm_target = pc_decode_i + imm_offset;

   assign branch_to_reg = jr_ready_i & !ctrl_interlock_i;

   // after a bubble the jr source has moved on, take it from execute
   assign reg_target = (execute_bubble_i | execute_ops_i[isa_pkg::OP_JR]) ?
                       execute_rfb_i : decode_rfb_i;

   assign decode_branch_o        = (branch_to_imm | branch_to_reg) & !flush_i;
   assign decode_branch_target_o = branch_to_imm ? imm_target : reg_target;
   assign ibus_align_o           = decode_branch_o & (|decode_branch_target_o[1:0]);

   assign next_pc = pc_decode_i + OPERAND_WIDTH'(PC_STEP);

   // predicted against the branch means the branch target is the fixup
   assign mispredict_target = ((decode_op_bf_i & !predicted_flag_i) |
                               (decode_op_bnf_i & predicted_flag_i)) ?
                              imm_target : next_pc;

   always_ff @(posedge clk) begin
      if (padv_i && decode_ops_i[isa_pkg::OP_BRCOND]) begin
         execute_predicted_flag_o    <= predicted_flag_i;
         execute_mispredict_target_o <= mispredict_target;
      end
   end

   // link address for l.jal/l.jalr
   always_ff @(posedge clk) begin
      if (padv_i) begin
         execute_jal_result_o <= next_pc;
      end
   end

endmodule

// ==== hdl/decode_execute.sv ====
`timescale 1ns/1ps

module decode_execute #(
   parameter int OPERAND_WIDTH = 32,
   parameter int RF_ADDR_WIDTH = 5,
   parameter bit DELAY_SLOT = 1'b1
) (
   input  logic                                   clk,
   input  logic                                   rst,
   input  logic                                   padv_i,
   input  logic                                   pipeline_flush_i,
   input  logic [OPERAND_WIDTH-1:0]               pc_decode_i,
   input  isa_pkg::op_flags_t                     decode_ops_i,
   input  logic                                   decode_op_rfe_i,
   input  logic                                   decode_op_bf_i,
   input  logic                                   decode_op_bnf_i,
   input  isa_pkg::opcode_t                       decode_opc_insn_i,
   input  isa_pkg::alu_opc_t                      decode_opc_alu_i,
   input  logic [isa_pkg::IMM16_WIDTH-1:0]        decode_imm16_i,
   input  logic [isa_pkg::IMMJBR_UPPER_WIDTH-1:0] decode_immjbr_upper_i,
   input  logic [OPERAND_WIDTH-1:0]               decode_immediate_i,
   input  logic                                   decode_immediate_sel_i,
   input  logic [RF_ADDR_WIDTH-1:0]               decode_rfd_adr_i,
   input  logic [RF_ADDR_WIDTH-1:0]               decode_rfa_adr_i,
   input  logic [RF_ADDR_WIDTH-1:0]               decode_rfb_adr_i,
   input  logic [OPERAND_WIDTH-1:0]               decode_rfb_i,
   input  logic [OPERAND_WIDTH-1:0]               execute_rfb_i,
   input  logic                                   predicted_flag_i,
   input  logic                                   ctrl_op_load_i,
   input  logic                                   ctrl_op_mfspr_i,
   input  logic [RF_ADDR_WIDTH-1:0]               ctrl_rfd_adr_i,
   input  logic                                   decode_except_illegal_i,
   input  logic                                   decode_except_syscall_i,
   output isa_pkg::op_flags_t                     execute_ops_o,
   output pipe_pkg::exc_flags_t                   execute_excs_o,
   output isa_pkg::opcode_t                       execute_opc_insn_o,
   output isa_pkg::alu_opc_t                      execute_opc_alu_o,
   output logic [OPERAND_WIDTH-1:0]               execute_immediate_o,
   output logic [RF_ADDR_WIDTH-1:0]               execute_rfd_adr_o,
   output logic [OPERAND_WIDTH-1:0]               pc_execute_o,
   output logic                                   execute_immediate_sel_o,
   output logic                                   execute_predicted_flag_o,
   output logic [OPERAND_WIDTH-1:0]               execute_mispredict_target_o,
   output logic [OPERAND_WIDTH-1:0]               execute_jal_result_o,
   output logic                                   decode_branch_o,
   output logic [OPERAND_WIDTH-1:0]               decode_branch_target_o,
   output logic                                   decode_valid_o,
   output logic                                   decode_bubble_o,
   output logic                                   execute_bubble_o
);

   typedef struct packed {
      logic [OPERAND_WIDTH-1:0] pc;
      logic [OPERAND_WIDTH-1:0] immediate;
      logic                     immediate_sel;
      isa_pkg::alu_opc_t        opc_alu;
      logic [RF_ADDR_WIDTH-1:0] rfd_adr;
   } operand_t;

   logic                 decode_bubble;
   logic                 ctrl_interlock;
   logic                 jr_ready;
   logic                 execute_bubble;
   logic                 ibus_align;
   pipe_pkg::exc_flags_t decode_excs;
   operand_t             decode_operands;
   operand_t             execute_operands;

   hazard_unit #(
      .RF_ADDR_WIDTH(RF_ADDR_WIDTH)
   ) u_hazard_unit (
      .clk               (clk),
      .rst               (rst),
      .padv_i            (padv_i),
      .flush_i           (pipeline_flush_i),
      .decode_rfa_adr_i  (decode_rfa_adr_i),
      .decode_rfb_adr_i  (decode_rfb_adr_i),
      .decode_op_jr_i    (decode_ops_i[isa_pkg::OP_JR]),
      .decode_op_rfe_i   (decode_op_rfe_i),
      .execute_ops_i     (execute_ops_o),
      .execute_rfd_adr_i (execute_operands.rfd_adr),
      .ctrl_op_load_i    (ctrl_op_load_i),
      .ctrl_op_mfspr_i   (ctrl_op_mfspr_i),
      .ctrl_rfd_adr_i    (ctrl_rfd_adr_i),
      .decode_bubble_o   (decode_bubble),
      .ctrl_interlock_o  (ctrl_interlock),
      .jr_ready_o        (jr_ready),
      .execute_bubble_o  (execute_bubble),
      .decode_valid_o    (decode_valid_o)
   );

   branch_resolver #(
      .OPERAND_WIDTH(OPERAND_WIDTH),
      .DELAY_SLOT   (DELAY_SLOT)
   ) u_branch_resolver (
      .clk                         (clk),
      .padv_i                      (padv_i),
      .flush_i                     (pipeline_flush_i),
      .pc_decode_i                 (pc_decode_i),
      .decode_ops_i                (decode_ops_i),
      .decode_opc_insn_i           (decode_opc_insn_i),
      .decode_op_bf_i              (decode_op_bf_i),
      .decode_op_bnf_i             (decode_op_bnf_i),
      .decode_imm16_i              (decode_imm16_i),
      .decode_immjbr_upper_i       (decode_immjbr_upper_i),
      .predicted_flag_i            (predicted_flag_i),
      .decode_rfb_i                (decode_rfb_i),
      .execute_rfb_i               (execute_rfb_i),
      .ctrl_interlock_i            (ctrl_interlock),
      .jr_ready_i                  (jr_ready),
      .execute_bubble_i            (execute_bubble),
      .execute_ops_i               (execute_ops_o),
      .decode_branch_o             (decode_branch_o),
      .decode_branch_target_o      (decode_branch_target_o),
      .ibus_align_o                (ibus_align),
      .execute_predicted_flag_o    (execute_predicted_flag_o),
      .execute_mispredict_target_o (execute_mispredict_target_o),
      .execute_jal_result_o        (execute_jal_result_o)
   );

   // rfe travels with the exceptions so a bubble does not drop it
   always_comb begin
      decode_excs = '0;
      decode_excs[pipe_pkg::EXC_RFE]        = decode_op_rfe_i;
      decode_excs[pipe_pkg::EXC_ILLEGAL]    = decode_except_illegal_i;
      decode_excs[pipe_pkg::EXC_SYSCALL]    = decode_except_syscall_i;
      decode_excs[pipe_pkg::EXC_IBUS_ALIGN] = ibus_align;
   end

   assign decode_operands.pc            = pc_decode_i;
   assign decode_operands.immediate     = decode_immediate_i;
   assign decode_operands.immediate_sel = decode_immediate_sel_i;
   assign decode_operands.opc_alu       = decode_opc_alu_i;
   assign decode_operands.rfd_adr       = decode_rfd_adr_i;

   stage_reg #(
      .payload_t     (isa_pkg::op_flags_t),
      .KILL_VALUE    ('0),
      .KILL_ON_BUBBLE(1'b1),
      .HAS_RESET     (1'b1)
   ) u_op_reg (
      .clk     (clk),
      .rst     (rst),
      .padv_i  (padv_i),
      .flush_i (pipeline_flush_i),
      .bubble_i(decode_bubble),
      .d_i     (decode_ops_i),
      .q_o     (execute_ops_o)
   );

   stage_reg #(
      .payload_t     (isa_pkg::opcode_t),
      .KILL_VALUE    (isa_pkg::OPCODE_NOP),
      .KILL_ON_BUBBLE(1'b1),
      .HAS_RESET     (1'b1)
   ) u_insn_reg (
      .clk     (clk),
      .rst     (rst),
      .padv_i  (padv_i),
      .flush_i (pipeline_flush_i),
      .bubble_i(decode_bubble),
      .d_i     (decode_opc_insn_i),
      .q_o     (execute_opc_insn_o)
   );

   stage_reg #(
      .payload_t     (pipe_pkg::exc_flags_t),
      .KILL_VALUE    ('0),
      .KILL_ON_BUBBLE(1'b0),
      .HAS_RESET     (1'b1)
   ) u_exc_reg (
      .clk     (clk),
      .rst     (rst),
      .padv_i  (padv_i),
      .flush_i (pipeline_flush_i),
      .bubble_i(decode_bubble),
      .d_i     (decode_excs),
      .q_o     (execute_excs_o)
   );

   stage_reg #(
      .payload_t     (operand_t),
      .KILL_ON_BUBBLE(1'b0),
      .HAS_RESET     (1'b0)
   ) u_operand_reg (
      .clk     (clk),
      .rst     (rst),
      .padv_i  (padv_i),
      .flush_i (pipeline_flush_i),
      .bubble_i(decode_bubble),
      .d_i     (decode_operands),
      .q_o     (execute_operands)
   );

   assign pc_execute_o            = execute_operands.pc;
   assign execute_immediate_o     = execute_operands.immediate;
   assign execute_immediate_sel_o = execute_operands.immediate_sel;
   assign execute_opc_alu_o       = execute_operands.opc_alu;
   assign execute_rfd_adr_o       = execute_operands.rfd_adr;

   assign decode_bubble_o  = decode_bubble;
   assign execute_bubble_o = execute_bubble;

endmodule

// ==== tb/tb_decode_execute.sv ====
`timescale 1ns/1ps

module tb_decode_execute;

   localparam int OPERAND_WIDTH = 32;
   localparam int RF_ADDR_WIDTH = 5;
   localparam int CLK_PERIOD    = 8;
   localparam int RESET_CYCLES  = 4;
   localparam string VECTOR_FILE = "tb/decode_execute_vectors.txt";

   // one cycle of stimulus, then the expected combinational and registered outputs
   typedef struct {
      int          test;
      logic        padv, flush;
      logic [31:0] pc;
      logic [15:0] ops;
      logic        rfe, bf, bnf;
      logic [5:0]  opc;
      logic [15:0] imm16;
      logic [9:0]  upper;
      logic [4:0]  rfd, rfa, rfb;
      logic [31:0] drfb, erfb;
      logic        pred, cload, cmfspr;
      logic [4:0]  crfd;
      logic        ill, sys;
      logic        x_bubble, x_branch;
      logic [31:0] x_target;
      logic [15:0] x_ops;
      logic [3:0]  x_excs;
      logic [5:0]  x_opc;
      logic [31:0] x_pc;
      logic        x_pflag;
      logic [31:0] x_mispt, x_jal;
      logic        x_ebubble, x_valid;
   } vector_t;

   logic clk;
   logic rst;
   logic padv_i, pipeline_flush_i;
   logic [OPERAND_WIDTH-1:0] pc_decode_i;
   isa_pkg::op_flags_t decode_ops_i;
   logic decode_op_rfe_i, decode_op_bf_i, decode_op_bnf_i;
   isa_pkg::opcode_t decode_opc_insn_i;
   isa_pkg::alu_opc_t decode_opc_alu_i;
   logic [isa_pkg::IMM16_WIDTH-1:0] decode_imm16_i;
   logic [isa_pkg::IMMJBR_UPPER_WIDTH-1:0] decode_immjbr_upper_i;
   logic [OPERAND_WIDTH-1:0] decode_immediate_i;
   logic decode_immediate_sel_i;
   logic [RF_ADDR_WIDTH-1:0] decode_rfd_adr_i, decode_rfa_adr_i, decode_rfb_adr_i;
   logic [OPERAND_WIDTH-1:0] decode_rfb_i, execute_rfb_i;
   logic predicted_flag_i, ctrl_op_load_i, ctrl_op_mfspr_i;
   logic [RF_ADDR_WIDTH-1:0] ctrl_rfd_adr_i;
   logic decode_except_illegal_i, decode_except_syscall_i;

   isa_pkg::op_flags_t execute_ops_o;
   pipe_pkg::exc_flags_t execute_excs_o;
   isa_pkg::opcode_t execute_opc_insn_o;
   isa_pkg::alu_opc_t execute_opc_alu_o;
   logic [OPERAND_WIDTH-1:0] execute_immediate_o, pc_execute_o;
   logic [RF_ADDR_WIDTH-1:0] execute_rfd_adr_o;
   logic execute_immediate_sel_o, execute_predicted_flag_o;
   logic [OPERAND_WIDTH-1:0] execute_mispredict_target_o, execute_jal_result_o;
   logic decode_branch_o;
   logic [OPERAND_WIDTH-1:0] decode_branch_target_o;
   logic decode_valid_o, decode_bubble_o, execute_bubble_o;

   // operand payload last captured on an advance
   logic [OPERAND_WIDTH-1:0] expected_immediate;
   logic                     expected_immediate_sel;
   isa_pkg::alu_opc_t        expected_opc_alu;
   logic [RF_ADDR_WIDTH-1:0] expected_rfd_adr;

   vector_t vectors[$];
   bit      load_failed;
   int      test_errors;
   int      tests_passed;
   int      tests_failed;
   int      current_test;
   longint  watchdog_ns;

   decode_execute #(
      .OPERAND_WIDTH(OPERAND_WIDTH),
      .RF_ADDR_WIDTH(RF_ADDR_WIDTH),
      .DELAY_SLOT   (1'b1)
   ) u_dut (
      .clk(clk), .rst(rst), .padv_i(padv_i), .pipeline_flush_i(pipeline_flush_i),
      .pc_decode_i(pc_decode_i), .decode_ops_i(decode_ops_i),
      .decode_op_rfe_i(decode_op_rfe_i), .decode_op_bf_i(decode_op_bf_i),
      .decode_op_bnf_i(decode_op_bnf_i), .decode_opc_insn_i(decode_opc_insn_i),
      .decode_opc_alu_i(decode_opc_alu_i), .decode_imm16_i(decode_imm16_i),
      .decode_immjbr_upper_i(decode_immjbr_upper_i), .decode_immediate_i(decode_immediate_i),
      .decode_immediate_sel_i(decode_immediate_sel_i), .decode_rfd_adr_i(decode_rfd_adr_i),
      .decode_rfa_adr_i(decode_rfa_adr_i), .decode_rfb_adr_i(decode_rfb_adr_i),
      .decode_rfb_i(decode_rfb_i), .execute_rfb_i(execute_rfb_i),
      .predicted_flag_i(predicted_flag_i), .ctrl_op_load_i(ctrl_op_load_i),
      .ctrl_op_mfspr_i(ctrl_op_mfspr_i), .ctrl_rfd_adr_i(ctrl_rfd_adr_i),
      .decode_except_illegal_i(decode_except_illegal_i),
      .decode_except_syscall_i(decode_except_syscall_i),
      .execute_ops_o(execute_ops_o), .execute_excs_o(execute_excs_o),
      .execute_opc_insn_o(execute_opc_insn_o), .execute_opc_alu_o(execute_opc_alu_o),
      .execute_immediate_o(execute_immediate_o), .execute_rfd_adr_o(execute_rfd_adr_o),
      .pc_execute_o(pc_execute_o), .execute_immediate_sel_o(execute_immediate_sel_o),
      .execute_predicted_flag_o(execute_predicted_flag_o),
      .execute_mispredict_target_o(execute_mispredict_target_o),
      .execute_jal_result_o(execute_jal_result_o), .decode_branch_o(decode_branch_o),
      .decode_branch_target_o(decode_branch_target_o), .decode_valid_o(decode_valid_o),
      .decode_bubble_o(decode_bubble_o), .execute_bubble_o(execute_bubble_o)
   );

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
      assert (got === expected) else begin
         $display("Error: %s got %h expected %h", name, got, expected);
         test_errors++;
      end
   endtask

   task automatic read_vector_file();
      int      fd;
      int      n;
      string   line;
      vector_t v;
      fd = $fopen(VECTOR_FILE, "r");
      if (fd == 0) begin
         $display("could not open the vector file %s", VECTOR_FILE);
         load_failed = 1'b1;
         return;
      end
      while (!$feof(fd)) begin
         line = "";
         n = $fgets(line, fd);
         // lines starting with # describe the columns
         if (n > 0 && line.substr(0, 0) != "#") begin
            n = $sscanf(line,
               "%d%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h",
               v.test, v.padv, v.flush, v.pc, v.ops, v.rfe, v.bf, v.bnf, v.opc, v.imm16,
               v.upper, v.rfd, v.rfa, v.rfb, v.drfb, v.erfb, v.pred, v.cload, v.cmfspr,
               v.crfd, v.ill, v.sys, v.x_bubble, v.x_branch, v.x_target, v.x_ops,
               v.x_excs, v.x_opc, v.x_pc, v.x_pflag, v.x_mispt, v.x_jal, v.x_ebubble,
               v.x_valid);
            if (n == 34) begin
               vectors.push_back(v);
            end else if (n > 0) begin
               $display("malformed line in the vector file: %s", line);
               load_failed = 1'b1;
            end
         end
      end
      $fclose(fd);
   endtask

   task automatic finish_test(input int number);
      if (test_errors == 0) begin
         tests_passed++;
         $display("test %0d passed", number);
      end else begin
         tests_failed++;
         $display("test %0d failed with %0d errors", number, test_errors);
      end
      test_errors = 0;
   endtask

   task automatic apply_vector(input vector_t v);
      @(negedge clk);
      padv_i = v.padv;
      pipeline_flush_i = v.flush;
      pc_decode_i = v.pc;
      decode_ops_i = v.ops;
      decode_op_rfe_i = v.rfe;
      decode_op_bf_i = v.bf;
      decode_op_bnf_i = v.bnf;
      decode_opc_insn_i = v.opc;
      decode_imm16_i = v.imm16;
      decode_immjbr_upper_i = v.upper;
      decode_rfd_adr_i = v.rfd;
      decode_rfa_adr_i = v.rfa;
      decode_rfb_adr_i = v.rfb;
      decode_rfb_i = v.drfb;
      execute_rfb_i = v.erfb;
      predicted_flag_i = v.pred;
      ctrl_op_load_i = v.cload;
      ctrl_op_mfspr_i = v.cmfspr;
      ctrl_rfd_adr_i = v.crfd;
      decode_except_illegal_i = v.ill;
      decode_except_syscall_i = v.sys;
      // operand payload patterns taken from the pc
      decode_immediate_i = ~v.pc;
      decode_immediate_sel_i = v.pc[2] ^ v.pc[8];
      decode_opc_alu_i = v.pc[11:8] ^ v.pc[5:2];
      // operand register loads on every advance and is never killed
      if (v.padv) begin
         expected_immediate = decode_immediate_i;
         expected_immediate_sel = decode_immediate_sel_i;
         expected_opc_alu = decode_opc_alu_i;
         expected_rfd_adr = v.rfd;
      end
      #1;
      check_value("decode_bubble_o", 32'(decode_bubble_o), 32'(v.x_bubble));
      check_value("decode_branch_o", 32'(decode_branch_o), 32'(v.x_branch));
      check_value("decode_branch_target_o", decode_branch_target_o, v.x_target);
      @(posedge clk);
      #1;
      check_value("execute_ops_o", 32'(execute_ops_o), 32'(v.x_ops));
      check_value("execute_excs_o", 32'(execute_excs_o), 32'(v.x_excs));
      check_value("execute_opc_insn_o", 32'(execute_opc_insn_o), 32'(v.x_opc));
      check_value("pc_execute_o", pc_execute_o, v.x_pc);
      check_value("execute_immediate_o", execute_immediate_o, expected_immediate);
      check_value("execute_immediate_sel_o", 32'(execute_immediate_sel_o),
                  32'(expected_immediate_sel));
      check_value("execute_opc_alu_o", 32'(execute_opc_alu_o), 32'(expected_opc_alu));
      check_value("execute_rfd_adr_o", 32'(execute_rfd_adr_o), 32'(expected_rfd_adr));
      check_value("execute_predicted_flag_o", 32'(execute_predicted_flag_o), 32'(v.x_pflag));
      check_value("execute_mispredict_target_o", execute_mispredict_target_o, v.x_mispt);
      check_value("execute_jal_result_o", execute_jal_result_o, v.x_jal);
      check_value("execute_bubble_o", 32'(execute_bubble_o), 32'(v.x_ebubble));
      check_value("decode_valid_o", 32'(decode_valid_o), 32'(v.x_valid));
   endtask

   // ends a run that stops making progress
   initial begin
      wait (watchdog_ns > 0);
      #(watchdog_ns);
      $display("timeout: the vectors did not finish in the expected time");
      $display("SOME TESTS FAILED");
      $finish;
   end

   initial begin
      rst = 1'b1;
      padv_i = 1'b0;
      pipeline_flush_i = 1'b0;
      pc_decode_i = '0;
      decode_ops_i = '0;
      decode_op_rfe_i = 1'b0;
      decode_op_bf_i = 1'b0;
      decode_op_bnf_i = 1'b0;
      decode_opc_insn_i = '0;
      decode_opc_alu_i = 4'h3;
      decode_imm16_i = '0;
      decode_immjbr_upper_i = '0;
      decode_immediate_i = 32'h0000_1234;
      decode_immediate_sel_i = 1'b1;
      decode_rfd_adr_i = '0;
      decode_rfa_adr_i = '0;
      decode_rfb_adr_i = '0;
      decode_rfb_i = '0;
      execute_rfb_i = '0;
      predicted_flag_i = 1'b0;
      ctrl_op_load_i = 1'b0;
      ctrl_op_mfspr_i = 1'b0;
      ctrl_rfd_adr_i = '0;
      decode_except_illegal_i = 1'b0;
      decode_except_syscall_i = 1'b0;
      watchdog_ns = 0;
      read_vector_file();
      watchdog_ns = longint'(vectors.size() + RESET_CYCLES + 16) * CLK_PERIOD;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      #1;
      // test 0 is the state right after reset
      check_value("execute_ops_o", 32'(execute_ops_o), 32'h0);
      check_value("execute_excs_o", 32'(execute_excs_o), 32'h0);
      check_value("execute_opc_insn_o", 32'(execute_opc_insn_o), 32'h05);
      check_value("execute_bubble_o", 32'(execute_bubble_o), 32'h0);
      check_value("decode_valid_o", 32'(decode_valid_o), 32'h0);
      current_test = 0;
      foreach (vectors[i]) begin
         if (vectors[i].test != current_test) begin
            finish_test(current_test);
            current_test = vectors[i].test;
         end
         apply_vector(vectors[i]);
      end
      finish_test(current_test);
      $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
      if (tests_failed == 0 && !load_failed && vectors.size() > 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

// ==== tb/decode_execute_vectors.txt ====
# test padv flush pc ops rfe bf bnf opc imm16 upper rfd rfa rfb drfb erfb pred cld cmf crfd ill sys
#   then bubble branch target, then after the edge: ops excs opc pc pflag mispt jal ebub valid
# test 1 reset, advance and stall
1 1 0 100 2400 0 0 1 03 0010 000 03 01 02 0 0 1 0 0 00 0 0 0 0 0 2400 0 03 100 1 140 108 0 1
1 1 0 104 8001 0 0 0 38 0000 000 04 01 02 0 0 0 0 0 00 0 0 0 0 0 8001 0 38 104 1 140 10c 0 1
1 0 0 200 0040 0 0 0 20 0000 000 07 01 02 0 0 0 0 0 00 0 0 0 0 0 8001 0 38 104 1 140 10c 0 0
# test 2 load-use bubble
2 1 0 108 8040 0 0 0 21 0000 000 05 01 02 0 0 0 0 0 00 0 0 0 0 0 8040 0 21 108 1 140 110 0 1
2 1 0 10c 8001 1 0 0 38 0000 000 06 05 02 0 0 0 0 0 00 0 0 1 0 0 0000 1 05 10c 1 140 114 1 1
2 1 0 10c 8001 0 0 0 38 0000 000 06 05 02 0 0 0 0 0 00 0 0 0 0 0 8001 0 38 10c 1 140 114 0 1
# test 3 immediate branch
3 1 0 200 0400 0 0 0 00 0008 000 00 00 00 0 0 0 0 0 00 0 0 0 1 220 0400 0 00 200 1 140 208 0 1
3 1 0 300 2400 0 1 0 04 fffc 3ff 00 00 00 0 0 1 0 0 00 0 0 0 1 2f0 2400 0 04 300 1 308 308 0 1
3 1 1 400 2400 0 1 0 04 0010 000 00 00 00 0 0 1 0 0 00 0 0 0 0 440 0000 0 05 400 1 408 408 0 1
3 1 0 502 0400 0 0 0 00 0001 000 00 00 00 0 0 1 0 0 00 0 0 0 1 506 0400 8 00 502 1 408 50a 0 1
# test 4 register branch
4 1 0 600 0800 0 0 0 11 0000 000 00 00 09 1000 2000 1 0 0 00 0 0 0 1 1000 0800 0 11 600 1 408 608 0 1
4 1 0 604 0000 1 0 0 05 0000 000 00 00 00 1000 2000 1 0 0 00 0 0 1 0 2000 0000 1 05 604 1 408 60c 1 1
4 1 0 700 0800 0 0 0 11 0000 000 00 00 09 1000 3000 1 0 0 00 0 0 0 1 3000 0800 0 11 700 1 408 708 0 1
4 1 0 800 0800 0 0 0 11 0000 000 00 00 09 1000 3000 1 1 0 09 0 0 1 0 3000 0000 0 05 800 1 408 808 1 1
# test 5 prediction and link
5 1 0 900 2400 0 0 1 03 0020 000 00 00 00 0 0 0 0 0 00 0 0 0 1 980 2400 0 03 900 0 908 908 0 1
5 1 0 a00 2400 0 1 0 04 0040 000 00 00 00 0 0 0 0 0 00 0 0 0 0 0 2400 0 04 a00 0 b00 a08 0 1
# test 6 flush priority and atomic store
6 1 1 b00 8001 1 0 0 38 0000 000 00 00 00 0 0 0 0 0 00 1 1 1 0 0 0000 0 05 b00 0 b00 b08 0 1
6 1 0 c00 0180 0 0 0 33 0000 000 00 01 02 0 0 0 0 0 00 0 0 0 0 0 0180 0 33 c00 0 b00 c08 0 1
6 1 0 c04 8001 0 0 0 38 0000 000 00 01 02 0 0 0 0 0 00 1 1 1 0 0 0000 6 05 c04 0 b00 c0c 1 1
6 0 0 c08 8001 0 0 0 38 0000 000 00 01 02 0 0 0 0 0 00 0 0 0 0 0 0000 6 05 c04 0 b00 c0c 1 0

// ==== tb.f ====
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/stage_reg.sv
hdl/hazard_unit.sv
hdl/branch_resolver.sv
hdl/decode_execute.sv
tb/tb_decode_execute.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_decode_execute
FILELIST  = tb.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
